//--- fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;

	// One instruction word read as I-type or as S-type
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			reg_idx_t   rs2;
			reg_idx_t   rs1;
			logic [2:0] funct3;
			reg_idx_t   rd;
			logic [6:0] opcode;
		} inst_i_view;
		struct packed {
			logic [6:0] imm_hi;
			reg_idx_t   rs2;
			reg_idx_t   rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} inst_s_view;
	} inst_word_t;

	// Boot address
	localparam addr_t reset_pc = 32'h3000_0000;

	// Cacheable window with an exclusive limit
	localparam addr_t cache_base  = 32'ha000_0000;
	localparam addr_t cache_limit = 32'ha200_0000;

	// Direct-mapped cache of 16 lines of 32 bytes
	localparam int line_words       = 8;
	localparam int line_offset_bits = 5;
	localparam int cache_lines      = 16;
	localparam int index_bits       = 4;
	localparam int tag_bits         = 23;

	// Read bus length and burst codes
	localparam logic [3:0] burst_len_code = 4'd7;
	localparam logic [1:0] burst_incr     = 2'b01;
	localparam logic [1:0] burst_fixed    = 2'b00;

	// Only the store opcode uses the S view
	localparam logic [6:0] opcode_store = 7'b0100011;

endpackage

`default_nettype wire

//--- fetch_pc.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_pc import fetch_pkg::*; (
	input  wire        clock,
	input  wire        reset,
	input  wire        redirect,
	input  wire addr_t redirect_addr,
	input  wire        fetch_done,
	input  wire        held,
	input  wire        out_taken,
	output addr_t      pc,
	output logic       cached,
	output logic       fetch_start,
	output logic       drop
);

	logic  busy;
	logic  pending;
	logic  want;
	addr_t target;
	logic  resolve;
	logic  want_next;
	logic  start_now;

	assign cached = (pc >= cache_base) && (pc < cache_limit);

	// Word of the fetch in flight is thrown away after a redirect
	assign drop = pending | (redirect & busy);

	assign resolve = busy & fetch_done & (pending | redirect);
	assign want_next = want | out_taken | (redirect & ~busy) | resolve;

	// A redirect clears the output register, so back-pressure no longer applies
	assign start_now = want_next & (~busy | fetch_done) & (~held | redirect);

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= reset_pc;
			busy <= 1'b0;
			pending <= 1'b0;
			want <= 1'b1;
			fetch_start <= 1'b0;
		end else begin
			fetch_start <= start_now;
			want <= want_next & ~start_now;
			if (start_now)
				busy <= 1'b1;
			else if (fetch_done)
				busy <= 1'b0;
			if (resolve)
				pending <= 1'b0;
			else if (redirect & busy)
				pending <= 1'b1;
			if (resolve)
				pc <= redirect ? redirect_addr : target;
			else if (redirect & ~busy)
				pc <= redirect_addr;
			else if (out_taken)
				pc <= pc + 32'd4;
		end
	end

	always_ff @(posedge clock) begin
		if (redirect)
			target <= redirect_addr;
	end

endmodule

`default_nettype wire

//--- fetch_icache.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_icache import fetch_pkg::*; (
	input  wire        clock,
	input  wire        reset,
	input  wire        fetch_start,
	input  wire addr_t pc,
	input  wire        cached,
	input  wire        refill_valid,
	input  wire addr_t refill_addr,
	input  wire word_t refill_word,
	output logic       lookup_done,
	output logic       hit,
	output word_t      hit_word
);

	logic [tag_bits-1:0]         tag_array [cache_lines];
	word_t                       data_array [cache_lines*line_words];
	logic [cache_lines-1:0]      line_valid;

	logic [index_bits-1:0]       pc_index;
	logic [tag_bits-1:0]         pc_tag;
	logic [line_offset_bits-3:0] pc_word;

	logic [index_bits-1:0]       fill_index;
	logic [tag_bits-1:0]         fill_tag;
	logic [line_offset_bits-3:0] fill_word;
	logic                        fill_first;
	logic                        fill_last;

	assign pc_index = pc[line_offset_bits +: index_bits];
	assign pc_tag = pc[line_offset_bits + index_bits +: tag_bits];
	assign pc_word = pc[line_offset_bits-1:2];

	assign fill_index = refill_addr[line_offset_bits +: index_bits];
	assign fill_tag = refill_addr[line_offset_bits + index_bits +: tag_bits];
	assign fill_word = refill_addr[line_offset_bits-1:2];

	// Refill always runs from word 0 up to the last word of the line
	assign fill_first = refill_valid && (fill_word == '0);
	assign fill_last = refill_valid && (fill_word == '1);

	// pc stays put for the whole fetch, so the lookup reads it directly
	assign hit = lookup_done & line_valid[pc_index] & (tag_array[pc_index] == pc_tag);
	assign hit_word = data_array[{pc_index, pc_word}];

	always_ff @(posedge clock) begin
		if (reset) begin
			lookup_done <= 1'b0;
			line_valid <= '0;
		end else begin
			lookup_done <= fetch_start & cached;
			if (fill_last)
				line_valid[fill_index] <= 1'b1;
			else if (fill_first)
				line_valid[fill_index] <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (refill_valid)
			data_array[{fill_index, fill_word}] <= refill_word;
		if (fill_last)
			tag_array[fill_index] <= fill_tag;
	end

endmodule

`default_nettype wire

//--- fetch_bus.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_bus import fetch_pkg::*; (
	input  wire        clock,
	input  wire        reset,
	input  wire        fetch_start,
	input  wire        cached,
	input  wire        lookup_done,
	input  wire        hit,
	input  wire word_t hit_word,
	input  wire addr_t pc,

	output addr_t      mem_araddr,
	output logic       mem_arvalid,
	input  wire        mem_arready,
	output logic [1:0] mem_arburst,
	output logic [3:0] mem_arlen,
	input  wire word_t mem_rdata,
	input  wire [1:0]  mem_rresp,
	input  wire        mem_rlast,
	input  wire        mem_rvalid,
	output logic       mem_rready,

	output logic       refill_valid,
	output addr_t      refill_addr,
	output word_t      refill_word,
	output logic       bus_done,
	output word_t      fetch_word
);

	logic  reading;
	logic  burst_mode;
	addr_t beat_addr;
	addr_t line_base;
	word_t picked_word;
	logic  beat;
	logic  want_beat;
	logic  uncached_start;
	logic  miss_start;

	assign mem_rready = 1'b1;

	assign uncached_start = fetch_start & ~cached;
	assign miss_start = lookup_done & ~hit;
	assign line_base = {pc[31:line_offset_bits], {line_offset_bits{1'b0}}};

	assign beat = mem_rvalid & mem_rready & reading;
	assign bus_done = beat & (~burst_mode | mem_rlast);

	// Critical word of a burst, or the only beat of a single read
	assign want_beat = beat &
		(~burst_mode | (beat_addr[line_offset_bits-1:2] == pc[line_offset_bits-1:2]));

	assign refill_valid = beat & burst_mode;
	assign refill_addr = beat_addr;
	assign refill_word = mem_rdata;

	assign fetch_word = (lookup_done & hit) ? hit_word :
		want_beat ? mem_rdata : picked_word;

	always_ff @(posedge clock) begin
		if (reset) begin
			mem_arvalid <= 1'b0;
			reading <= 1'b0;
			burst_mode <= 1'b0;
		end else if (uncached_start) begin
			mem_arvalid <= 1'b1;
			reading <= 1'b1;
			burst_mode <= 1'b0;
		end else if (miss_start) begin
			mem_arvalid <= 1'b1;
			reading <= 1'b1;
			burst_mode <= 1'b1;
		end else begin
			if (mem_arvalid & mem_arready)
				mem_arvalid <= 1'b0;
			if (bus_done)
				reading <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (uncached_start) begin
			mem_araddr <= pc;
			mem_arlen <= 4'd0;
			mem_arburst <= burst_fixed;
		end else if (miss_start) begin
			mem_araddr <= line_base;
			mem_arlen <= burst_len_code;
			mem_arburst <= burst_incr;
			beat_addr <= line_base;
		end else if (beat) begin
			beat_addr <= beat_addr + 32'd4;
		end
		if (want_beat)
			picked_word <= mem_rdata;
	end

endmodule

`default_nettype wire

//--- fetch_decode.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_decode import fetch_pkg::*; (
	input  wire        clock,
	input  wire        reset,
	input  wire        fetch_done,
	input  wire        drop,
	input  wire        redirect,
	input  wire word_t fetch_word,
	input  wire addr_t pc,
	input  wire        out_ready,
	output logic       out_valid,
	output addr_t      out_pc,
	output word_t      inst,
	output reg_idx_t   rd,
	output reg_idx_t   rs1,
	output reg_idx_t   rs2,
	output word_t      imm,
	output logic       held,
	output logic       out_taken
);

	inst_word_t inst_q;
	logic       capture;

	assign capture = fetch_done & ~drop;
	assign held = out_valid & ~out_ready;
	assign out_taken = out_valid & out_ready;

	always_ff @(posedge clock) begin
		if (reset)
			out_valid <= 1'b0;
		else if (redirect)
			out_valid <= 1'b0;
		else if (capture)
			out_valid <= 1'b1;
		else if (out_taken)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (capture) begin
			inst_q <= fetch_word;
			out_pc <= pc;
		end
	end

	assign inst = inst_q;
	assign rd = inst_q.inst_i_view.rd;
	assign rs1 = inst_q.inst_i_view.rs1;
	assign rs2 = inst_q.inst_i_view.rs2;

	// Stores split the immediate around rd
	always_comb begin
		if (inst_q.inst_s_view.opcode == opcode_store)
			imm = {{20{inst_q.inst_s_view.imm_hi[6]}},
				inst_q.inst_s_view.imm_hi, inst_q.inst_s_view.imm_lo};
		else
			imm = {{20{inst_q.inst_i_view.funct7[6]}},
				inst_q.inst_i_view.funct7, inst_q.inst_i_view.rs2};
	end

endmodule

`default_nettype wire

//--- fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
	input  wire        clock,
	input  wire        reset,
	input  wire        redirect,
	input  wire addr_t redirect_addr,
	input  wire        out_ready,

	output addr_t      mem_araddr,
	output logic       mem_arvalid,
	input  wire        mem_arready,
	output logic [1:0] mem_arburst,
	output logic [3:0] mem_arlen,
	input  wire word_t mem_rdata,
	input  wire [1:0]  mem_rresp,
	input  wire        mem_rlast,
	input  wire        mem_rvalid,
	output logic       mem_rready,

	output logic       out_valid,
	output addr_t      out_pc,
	output word_t      inst,
	output reg_idx_t   rd,
	output reg_idx_t   rs1,
	output reg_idx_t   rs2,
	output word_t      imm
);

	addr_t pc;
	logic  cached;
	logic  fetch_start;
	logic  drop;
	logic  held;
	logic  out_taken;
	logic  lookup_done;
	logic  hit;
	word_t hit_word;
	logic  refill_valid;
	addr_t refill_addr;
	word_t refill_word;
	logic  bus_done;
	word_t fetch_word;
	logic  fetch_done;

	// Cache hit or end of a bus read
	assign fetch_done = (lookup_done & hit) | bus_done;

	fetch_pc u_pc (
		.clock(clock), .reset(reset),
		.redirect(redirect), .redirect_addr(redirect_addr),
		.fetch_done(fetch_done), .held(held), .out_taken(out_taken),
		.pc(pc), .cached(cached), .fetch_start(fetch_start), .drop(drop)
	);

	fetch_icache u_icache (
		.clock(clock), .reset(reset),
		.fetch_start(fetch_start), .pc(pc), .cached(cached),
		.refill_valid(refill_valid), .refill_addr(refill_addr), .refill_word(refill_word),
		.lookup_done(lookup_done), .hit(hit), .hit_word(hit_word)
	);

	fetch_bus u_bus (
		.clock(clock), .reset(reset),
		.fetch_start(fetch_start), .cached(cached), .lookup_done(lookup_done),
		.hit(hit), .hit_word(hit_word), .pc(pc),
		.mem_araddr(mem_araddr), .mem_arvalid(mem_arvalid), .mem_arready(mem_arready),
		.mem_arburst(mem_arburst), .mem_arlen(mem_arlen), .mem_rdata(mem_rdata),
		.mem_rresp(mem_rresp), .mem_rlast(mem_rlast), .mem_rvalid(mem_rvalid),
		.mem_rready(mem_rready),
		.refill_valid(refill_valid), .refill_addr(refill_addr), .refill_word(refill_word),
		.bus_done(bus_done), .fetch_word(fetch_word)
	);

	fetch_decode u_decode (
		.clock(clock), .reset(reset),
		.fetch_done(fetch_done), .drop(drop), .redirect(redirect),
		.fetch_word(fetch_word), .pc(pc), .out_ready(out_ready),
		.out_valid(out_valid), .out_pc(out_pc), .inst(inst),
		.rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm),
		.held(held), .out_taken(out_taken)
	);

endmodule

`default_nettype wire

//--- fetch_tb.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_tb import fetch_pkg::*; ();

	logic       clock = 1'b0;
	logic       reset;
	logic       redirect;
	addr_t      redirect_addr;
	logic       out_ready;
	addr_t      mem_araddr;
	logic       mem_arvalid;
	logic       mem_arready;
	logic [1:0] mem_arburst;
	logic [3:0] mem_arlen;
	word_t      mem_rdata;
	logic [1:0] mem_rresp;
	logic       mem_rlast;
	logic       mem_rvalid;
	logic       mem_rready;
	logic       out_valid;
	addr_t      out_pc;
	word_t      inst;
	reg_idx_t   rd;
	reg_idx_t   rs1;
	reg_idx_t   rs2;
	word_t      imm;

	// One entry per golden record
	logic [7:0] rec_ready[$];
	logic       rec_redir[$];
	int         rec_offset[$];
	addr_t      rec_target[$];
	addr_t      rec_pc[$];
	word_t      rec_inst[$];
	word_t      rec_imm[$];
	int         rec_reqs[$];

	int         req_count = 0;
	logic       loaded = 1'b0;
	integer     seed;

	fetch_top DUT (
		.clock(clock), .reset(reset),
		.redirect(redirect), .redirect_addr(redirect_addr), .out_ready(out_ready),
		.mem_araddr(mem_araddr), .mem_arvalid(mem_arvalid), .mem_arready(mem_arready),
		.mem_arburst(mem_arburst), .mem_arlen(mem_arlen), .mem_rdata(mem_rdata),
		.mem_rresp(mem_rresp), .mem_rlast(mem_rlast), .mem_rvalid(mem_rvalid),
		.mem_rready(mem_rready),
		.out_valid(out_valid), .out_pc(out_pc), .inst(inst),
		.rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm)
	);

	always #5 clock = ~clock;

	// Memory content is the address rotated left by 7 and XORed
	function automatic word_t rule_word(input addr_t a);
		return {a[24:0], a[31:25]} ^ 32'h5a5a_0013;
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
		if (actual !== expected)
			abort_run($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected)
			abort_run($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic check_idx(input string name, input reg_idx_t expected, input reg_idx_t actual);
		if (actual !== expected)
			abort_run($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			abort_run($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected)
			abort_run($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic load_golden();
		integer     fd;
		integer     n;
		string      line;
		logic [7:0] ready;
		logic       redir;
		int         offset;
		addr_t      target;
		addr_t      pc;
		word_t      word;
		word_t      imm_val;
		int         reqs;
		fd = $fopen("fetch_golden.txt", "r");
		if (fd == 0)
			abort_run("The golden data file could not be opened");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line[0] != "#") begin
				n = $sscanf(line, "%h %h %d %h %h %h %h %d",
					ready, redir, offset, target, pc, word, imm_val, reqs);
				if (n != 8)
					abort_run("A golden record does not have eight columns");
				rec_ready.push_back(ready);
				rec_redir.push_back(redir);
				rec_offset.push_back(offset);
				rec_target.push_back(target);
				rec_pc.push_back(pc);
				rec_inst.push_back(word);
				rec_imm.push_back(imm_val);
				rec_reqs.push_back(reqs);
			end
		end
		$fclose(fd);
		if (rec_pc.size() == 0)
			abort_run("The golden data file holds no records");
	endtask

	task automatic check_output(input int idx);
		inst_word_t fields;
		fields = rec_inst[idx];
		check_addr("out_pc", rec_pc[idx], out_pc);
		check_word("inst", rec_inst[idx], inst);
		check_word("imm", rec_imm[idx], imm);
		check_idx("rd", fields.inst_i_view.rd, rd);
		check_idx("rs1", fields.inst_i_view.rs1, rs1);
		check_idx("rs2", fields.inst_i_view.rs2, rs2);
		check_count("bus requests", rec_reqs[idx], req_count);
	endtask

	// Drive one record cycle by cycle until its output is taken
	task automatic run_record(input int idx);
		int    cyc;
		logic  taken;
		logic  holding;
		addr_t held_pc;
		word_t held_inst;
		cyc = 0;
		taken = 1'b0;
		holding = 1'b0;
		while (!taken) begin
			@(posedge clock);
			#1;
			out_ready = rec_ready[idx][cyc % 8];
			redirect = rec_redir[idx] && (cyc == rec_offset[idx]);
			redirect_addr = rec_target[idx];
			@(negedge clock);
			if (holding) begin
				check_bit("out_valid", 1'b1, out_valid);
				check_addr("out_pc", held_pc, out_pc);
				check_word("inst", held_inst, inst);
			end
			if (out_valid && out_ready) begin
				check_output(idx);
				taken = 1'b1;
			end else if (out_valid) begin
				holding = 1'b1;
				held_pc = out_pc;
				held_inst = inst;
			end
			cyc++;
		end
	endtask

	task automatic check_request(input addr_t addr, input logic [3:0] len,
			input logic [1:0] burst);
		logic in_region;
		in_region = (addr >= cache_base) && (addr < cache_limit);
		if (len == burst_len_code) begin
			if (burst != burst_incr)
				abort_run("A line refill was not requested as an incrementing burst");
			if (!in_region)
				abort_run("A line refill was requested outside the cacheable region");
			check_addr("mem_araddr", addr & ~32'h1f, addr);
		end else if (len == 4'd0) begin
			if (burst != burst_fixed)
				abort_run("A single read was not requested with the fixed burst code");
			if (in_region)
				abort_run("A single read was requested inside the cacheable region");
		end else begin
			abort_run("A read request has a length that is neither one nor eight beats");
		end
	endtask

	// Memory responder with random accept delay and beat spacing
	initial begin : responder
		addr_t      beat_addr;
		logic [3:0] len;
		logic [1:0] burst;
		int         delay;
		int         beat;
		seed = 32'hec68_13b2;
		mem_arready = 1'b0;
		mem_rvalid = 1'b0;
		mem_rlast = 1'b0;
		mem_rdata = '0;
		mem_rresp = 2'b00;
		forever begin
			@(negedge clock);
			if (!reset && mem_arvalid === 1'b1) begin
				req_count++;
				beat_addr = mem_araddr;
				len = mem_arlen;
				burst = mem_arburst;
				check_request(beat_addr, len, burst);
				delay = $unsigned($random(seed)) % 4;
				repeat (delay) @(posedge clock);
				@(posedge clock);
				#1 mem_arready = 1'b1;
				@(posedge clock);
				#1 mem_arready = 1'b0;
				for (beat = 0; beat <= len; beat++) begin
					delay = $unsigned($random(seed)) % 3;
					repeat (delay) begin
						@(posedge clock);
						#1;
					end
					mem_rvalid = 1'b1;
					mem_rdata = rule_word(beat_addr);
					mem_rlast = (beat == len);
					@(negedge clock);
					check_bit("mem_rready", 1'b1, mem_rready);
					@(posedge clock);
					#1;
					mem_rvalid = 1'b0;
					mem_rlast = 1'b0;
					beat_addr = beat_addr + 32'd4;
				end
			end
		end
	end

	initial begin : watchdog
		wait (loaded);
		repeat (rec_pc.size() * 40) @(posedge clock);
		abort_run("The fetch stalled and not all golden records were seen in time");
	end

	initial begin
		int rec;
		reset = 1'b1;
		redirect = 1'b0;
		redirect_addr = '0;
		out_ready = 1'b0;
		load_golden();
		loaded = 1'b1;
		repeat (5) @(posedge clock);
		#1 reset = 1'b0;
		for (rec = 0; rec < rec_pc.size(); rec++)
			run_record(rec);
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- fetch_golden.txt
# ready redirect offset target | out_pc inst imm requests (all hex except offset and requests)
# ready is out_ready per cycle, LSB first, repeating; requests is the bus request total so far
ff 0 0 00000000 30000000 5a5a000b 000005a5 1
80 0 0 00000000 30000004 5a5a020b 000005a5 2
ff 0 0 00000000 30000008 5a5a040b 000005a5 3
ff 1 1 61000040 61000040 da5a2023 fffffda0 5
88 0 0 00000000 61000044 da5a2223 fffffda4 6
ff 1 1 a0000108 a0000108 5a5a8443 000005a5 8
ff 0 0 00000000 a000010c 5a5a8643 000005a5 8
80 0 0 00000000 a0000110 5a5a8843 000005a5 8
ff 0 0 00000000 a0000114 5a5a8a43 000005a5 8
ff 0 0 00000000 a0000118 5a5a8c43 000005a5 8
ff 0 0 00000000 a000011c 5a5a8e43 000005a5 8
ff 1 2 a0000100 a0000100 5a5a8043 000005a5 9
ff 0 0 00000000 a0000104 5a5a8243 000005a5 9
ff 0 0 00000000 a0000108 5a5a8443 000005a5 9
c0 0 0 00000000 a000010c 5a5a8643 000005a5 9
ff 0 0 00000000 a0000110 5a5a8843 000005a5 9
ff 0 0 00000000 a0000114 5a5a8a43 000005a5 9
ff 0 0 00000000 a0000118 5a5a8c43 000005a5 9
ff 0 0 00000000 a000011c 5a5a8e43 000005a5 9
ff 0 0 00000000 a0000120 5a5a9043 000005a5 9
80 0 0 00000000 a0000124 5a5a9243 000005a5 9
ff 0 0 00000000 a0000128 5a5a9443 000005a5 9

//--- fetch.f
fetch_pkg.sv
fetch_pc.sv
fetch_icache.sv
fetch_bus.sv
fetch_decode.sv
fetch_top.sv
fetch_tb.sv

//--- Bender.yml
package:
  name: fetch
  description: "Instruction fetch front end with a direct-mapped instruction cache"

sources:
  - files:
      - fetch_pkg.sv
      - fetch_pc.sv
      - fetch_icache.sv
      - fetch_bus.sv
      - fetch_decode.sv
      - fetch_top.sv
  - target: simulation
    files:
      - fetch_tb.sv

# Top modules: fetch_top for synthesis, fetch_tb for simulation
